// ==== rs_core.f ====
+incdir+testbench
src/rs_pkg.sv
src/rs_priority_pick.sv
src/rs_tag_cam.sv
src/rs_entry_table.sv
src/rs_issue_select.sv
src/rs_top.sv
testbench/rs_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary -j 0 --assert
TOP       = rs_tb
FILE_LIST = rs_core.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILE_LIST))) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/rs_tb_vectors.svh ====
//------------------------------
// reservation station vectors
// one row per cycle, stimulus and expected outputs
//------------------------------

// stimulus columns: dispatch, fu, op, dest, src1, src2, {src1, src2} ready,
// cdb valid, cdb tag, {ld_ready, st_ready, flush}
typedef struct packed {
	logic             dispatch;
	fu_kind_t         fu;
	logic [op_w-1:0]  op;
	logic [tag_w-1:0] dest;
	logic [tag_w-1:0] src1;
	logic [tag_w-1:0] src2;
	logic [1:0]       src_ready;
	logic             cdb_valid;
	logic [tag_w-1:0] cdb_tag;
	logic [2:0]       ctl;
} stim_t;

// expected columns: issue_valid, checked slice, op, dest, src1, src2, rs_full
// values are the outputs seen while the row is driven
typedef struct packed {
	logic [num_fu-1:0] issue;
	fu_kind_t          fu;
	logic [op_w-1:0]   op;
	logic [tag_w-1:0]  dest;
	logic [tag_w-1:0]  src1;
	logic [tag_w-1:0]  src2;
	logic              full;
} want_t;

localparam int num_vec = 33;

// nothing dispatched, both queues open
localparam stim_t idle_stim = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b0, 6'd0, 3'b110};
// no issue, not full
localparam want_t quiet_want = '{5'b00000, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 1'b0};

stim_t stim [num_vec];
want_t want [num_vec];

task automatic fill_vector_table();
	for (int i = 0; i < num_vec; i++) begin
		stim[i] = idle_stim;
		want[i] = quiet_want;
	end
	// ready alu, out two cycles later
	stim[0] = '{1'b1, fu_alu, 4'h3, 6'd20, 6'd1, 6'd2, 2'b11, 1'b0, 6'd0, 3'b110};
	want[2] = '{5'b00001, fu_alu, 4'h3, 6'd20, 6'd1, 6'd2, 1'b0};
	// waits on 9 and 12
	stim[3] = '{1'b1, fu_alu, 4'h5, 6'd21, 6'd9, 6'd12, 2'b00, 1'b0, 6'd0, 3'b110};
	stim[4] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b1, 6'd9, 3'b110};
	// broadcast of 12 with a dispatch that needs 12
	stim[6] = '{1'b1, fu_alu, 4'h6, 6'd22, 6'd12, 6'd3, 2'b01, 1'b1, 6'd12, 3'b110};
	want[7] = '{5'b00001, fu_alu, 4'h5, 6'd21, 6'd9, 6'd12, 1'b0};
	want[8] = '{5'b00001, fu_alu, 4'h6, 6'd22, 6'd12, 6'd3, 1'b0};
	// alu, mult, branch all woken by 40
	stim[8] = '{1'b1, fu_alu, 4'h1, 6'd30, 6'd40, 6'd4, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[9] = '{1'b1, fu_mult, 4'h2, 6'd31, 6'd40, 6'd5, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[10] = '{1'b1, fu_br, 4'h3, 6'd32, 6'd40, 6'd6, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[11] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b1, 6'd40, 3'b110};
	want[12] = '{5'b11001, fu_mult, 4'h2, 6'd31, 6'd40, 6'd5, 1'b0};
	// two alus on 41, entry 3 before entry 2
	stim[12] = '{1'b1, fu_alu, 4'h7, 6'd33, 6'd41, 6'd7, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[13] = '{1'b1, fu_alu, 4'h8, 6'd34, 6'd41, 6'd8, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[14] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b1, 6'd41, 3'b110};
	want[15] = '{5'b00001, fu_alu, 4'h7, 6'd33, 6'd41, 6'd7, 1'b0};
	want[16] = '{5'b00001, fu_alu, 4'h8, 6'd34, 6'd41, 6'd8, 1'b0};
	// load and store held by closed queues
	stim[16] = '{1'b1, fu_ld, 4'h9, 6'd35, 6'd10, 6'd11, 2'b11, 1'b0, 6'd0, 3'b000};
	stim[17] = '{1'b1, fu_st, 4'ha, 6'd36, 6'd13, 6'd14, 2'b11, 1'b0, 6'd0, 3'b000};
	stim[18] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b0, 6'd0, 3'b000};
	stim[19] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b0, 6'd0, 3'b100};
	want[20] = '{5'b00010, fu_ld, 4'h9, 6'd35, 6'd10, 6'd11, 1'b0};
	want[21] = '{5'b00100, fu_st, 4'ha, 6'd36, 6'd13, 6'd14, 1'b0};
	// four waiting entries fill the table
	stim[21] = '{1'b1, fu_alu, 4'hb, 6'd41, 6'd50, 6'd1, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[22] = '{1'b1, fu_mult, 4'hc, 6'd42, 6'd50, 6'd1, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[23] = '{1'b1, fu_br, 4'hd, 6'd43, 6'd50, 6'd1, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[24] = '{1'b1, fu_alu, 4'he, 6'd44, 6'd50, 6'd1, 2'b01, 1'b0, 6'd0, 3'b110};
	// fifth one is dropped, its tag 53 wakes nothing
	stim[25] = '{1'b1, fu_alu, 4'hf, 6'd45, 6'd53, 6'd2, 2'b01, 1'b0, 6'd0, 3'b110};
	stim[26] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b1, 6'd53, 3'b110};
	// flush, then 50 finds an empty table
	stim[28] = '{1'b0, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 2'b00, 1'b0, 6'd0, 3'b111};
	// a ready branch rides along, out two cycles later on its own slice
	stim[30] = '{1'b1, fu_br, 4'h4, 6'd46, 6'd15, 6'd16, 2'b11, 1'b1, 6'd50, 3'b110};
	want[32] = '{5'b10000, fu_br, 4'h4, 6'd46, 6'd15, 6'd16, 1'b0};
	for (int i = 25; i < 29; i++) begin
		want[i] = '{5'b00000, fu_alu, 4'h0, 6'd0, 6'd0, 6'd0, 1'b1};
	end
endtask

// ==== testbench/rs_tb.sv ====
//------------------------------
// reservation station testbench
// table driven, four entry table
//------------------------------

module rs_tb;

	import rs_pkg::*;

	localparam int reset_cycles = 16;

	logic                           clock;
	logic                           rst_n;
	logic                           dispatch_valid;
	fu_kind_t                       dispatch_fu;
	logic [op_w-1:0]                dispatch_op;
	logic [tag_w-1:0]               dispatch_dest;
	logic [tag_w-1:0]               dispatch_src1;
	logic                           dispatch_src1_ready;
	logic [tag_w-1:0]               dispatch_src2;
	logic                           dispatch_src2_ready;
	logic                           rs_full;
	logic                           cdb_valid;
	logic [tag_w-1:0]               cdb_tag;
	logic                           ld_ready;
	logic                           st_ready;
	logic                           flush;
	logic [num_fu-1:0]              issue_valid;
	logic [num_fu-1:0][op_w-1:0]    issue_op;
	logic [num_fu-1:0][tag_w-1:0]   issue_dest;
	logic [num_fu-1:0][tag_w-1:0]   issue_src1;
	logic [num_fu-1:0][tag_w-1:0]   issue_src2;
	int                             cycle_count;

	`include "rs_tb_vectors.svh"

	// run limit from table length and reset
	localparam int cycle_limit = 2 * num_vec + reset_cycles;

	// small table so full is easy to reach
	rs_top #(
		.rs_size (4)
	) rs_top_inst (
		.clock               (clock),
		.rst_n               (rst_n),
		.dispatch_valid      (dispatch_valid),
		.dispatch_fu         (dispatch_fu),
		.dispatch_op         (dispatch_op),
		.dispatch_dest       (dispatch_dest),
		.dispatch_src1       (dispatch_src1),
		.dispatch_src1_ready (dispatch_src1_ready),
		.dispatch_src2       (dispatch_src2),
		.dispatch_src2_ready (dispatch_src2_ready),
		.rs_full             (rs_full),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag),
		.ld_ready            (ld_ready),
		.st_ready            (st_ready),
		.flush               (flush),
		.issue_valid         (issue_valid),
		.issue_op            (issue_op),
		.issue_dest          (issue_dest),
		.issue_src1          (issue_src1),
		.issue_src2          (issue_src2)
	);

	//------------------------------
	// clock and run limit
	//------------------------------

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the vector loop did not finish within %0d cycles", cycle_limit);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped by the cycle limit");
	end

	//------------------------------
	// helpers
	//------------------------------

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what, input int row);
		if (actual !== expected) begin
			$display("error at %0t: row %0d %s is %0h, expected %0h",
				$time, row, what, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on the issue ports or full flag");
		end
	endtask

	// row inputs, called right after a rising edge
	task automatic drive_row(input int r);
		dispatch_valid      <= stim[r].dispatch;
		dispatch_fu         <= stim[r].fu;
		dispatch_op         <= stim[r].op;
		dispatch_dest       <= stim[r].dest;
		dispatch_src1       <= stim[r].src1;
		dispatch_src2       <= stim[r].src2;
		dispatch_src1_ready <= stim[r].src_ready[1];
		dispatch_src2_ready <= stim[r].src_ready[0];
		cdb_valid           <= stim[r].cdb_valid;
		cdb_tag             <= stim[r].cdb_tag;
		ld_ready            <= stim[r].ctl[2];
		st_ready            <= stim[r].ctl[1];
		flush               <= stim[r].ctl[0];
	endtask

	task automatic compare_row(input int r);
		fu_kind_t s;
		s = want[r].fu;
		check(32'(issue_valid), 32'(want[r].issue), "issue_valid", r);
		check(32'(rs_full), 32'(want[r].full), "rs_full", r);
		// slice fields only on a valid slice
		if (want[r].issue[s]) begin
			check(32'(issue_op[s]), 32'(want[r].op), "issue_op", r);
			check(32'(issue_dest[s]), 32'(want[r].dest), "issue_dest", r);
			check(32'(issue_src1[s]), 32'(want[r].src1), "issue_src1", r);
			check(32'(issue_src2[s]), 32'(want[r].src2), "issue_src2", r);
		end
	endtask

	//------------------------------
	// main sequence
	//------------------------------

	initial begin
		rst_n               = 1'b0;
		dispatch_valid      = 1'b0;
		dispatch_fu         = fu_alu;
		dispatch_op         = '0;
		dispatch_dest       = '0;
		dispatch_src1       = '0;
		dispatch_src1_ready = 1'b0;
		dispatch_src2       = '0;
		dispatch_src2_ready = 1'b0;
		cdb_valid           = 1'b0;
		cdb_tag             = '0;
		ld_ready            = 1'b1;
		st_ready            = 1'b1;
		flush               = 1'b0;
		fill_vector_table();
		repeat (reset_cycles) @(posedge clock);
		rst_n <= 1'b1;
		// drive on the edge, check mid cycle
		for (int r = 0; r < num_vec; r++) begin
			@(posedge clock);
			drive_row(r);
			@(negedge clock);
			compare_row(r);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== src/rs_top.sv ====
//------------------------------
// reservation station top
// entry table, tag match and issue selection
//------------------------------

module rs_top #(
	parameter int rs_size = 12
) (
	input  logic                                          clock,
	input  logic                                          rst_n,
	// dispatch from rename
	input  logic                                          dispatch_valid,
	input  rs_pkg::fu_kind_t                              dispatch_fu,
	input  logic [rs_pkg::op_w-1:0]                       dispatch_op,
	input  logic [rs_pkg::tag_w-1:0]                      dispatch_dest,
	input  logic [rs_pkg::tag_w-1:0]                      dispatch_src1,
	input  logic                                          dispatch_src1_ready,
	input  logic [rs_pkg::tag_w-1:0]                      dispatch_src2,
	input  logic                                          dispatch_src2_ready,
	output logic                                          rs_full,
	// result bus
	input  logic                                          cdb_valid,
	input  logic [rs_pkg::tag_w-1:0]                      cdb_tag,
	// load/store queue space
	input  logic                                          ld_ready,
	input  logic                                          st_ready,
	input  logic                                          flush,
	// issue ports, one slice per class
	output logic [rs_pkg::num_fu-1:0]                     issue_valid,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::op_w-1:0]   issue_op,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_dest,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_src1,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_src2
);

	import rs_pkg::*;

	// flat entry view
	logic [rs_size-1:0]              entry_busy;
	fu_kind_t [rs_size-1:0]          entry_fu;
	logic [rs_size-1:0][op_w-1:0]    entry_op;
	logic [rs_size-1:0][tag_w-1:0]   entry_dest;
	logic [rs_size-1:0][tag_w-1:0]   entry_src1;
	logic [rs_size-1:0]              entry_src1_ready;
	logic [rs_size-1:0][tag_w-1:0]   entry_src2;
	logic [rs_size-1:0]              entry_src2_ready;
	logic [rs_size-1:0]              src1_hit;
	logic [rs_size-1:0]              src2_hit;
	logic [rs_size-1:0]              issue_grant;

	rs_tag_cam #(
		.rs_size (rs_size)
	) tag_cam_inst (
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.entry_busy (entry_busy),
		.entry_src1 (entry_src1),
		.entry_src2 (entry_src2),
		.src1_hit   (src1_hit),
		.src2_hit   (src2_hit)
	);

	rs_entry_table #(
		.rs_size (rs_size)
	) entry_table_inst (
		.clock               (clock),
		.rst_n               (rst_n),
		.flush               (flush),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag),
		.dispatch_valid      (dispatch_valid),
		.dispatch_fu         (dispatch_fu),
		.dispatch_op         (dispatch_op),
		.dispatch_dest       (dispatch_dest),
		.dispatch_src1       (dispatch_src1),
		.dispatch_src1_ready (dispatch_src1_ready),
		.dispatch_src2       (dispatch_src2),
		.dispatch_src2_ready (dispatch_src2_ready),
		.src1_hit            (src1_hit),
		.src2_hit            (src2_hit),
		.issue_grant         (issue_grant),
		.rs_full             (rs_full),
		.entry_busy          (entry_busy),
		.entry_fu            (entry_fu),
		.entry_op            (entry_op),
		.entry_dest          (entry_dest),
		.entry_src1          (entry_src1),
		.entry_src1_ready    (entry_src1_ready),
		.entry_src2          (entry_src2),
		.entry_src2_ready    (entry_src2_ready)
	);

	rs_issue_select #(
		.rs_size (rs_size)
	) issue_select_inst (
		.clock            (clock),
		.rst_n            (rst_n),
		.flush            (flush),
		.ld_ready         (ld_ready),
		.st_ready         (st_ready),
		.entry_busy       (entry_busy),
		.entry_fu         (entry_fu),
		.entry_op         (entry_op),
		.entry_dest       (entry_dest),
		.entry_src1       (entry_src1),
		.entry_src1_ready (entry_src1_ready),
		.entry_src2       (entry_src2),
		.entry_src2_ready (entry_src2_ready),
		.issue_grant      (issue_grant),
		.issue_valid      (issue_valid),
		.issue_op         (issue_op),
		.issue_dest       (issue_dest),
		.issue_src1       (issue_src1),
		.issue_src2       (issue_src2)
	);

endmodule

// ==== src/rs_issue_select.sv ====
//------------------------------
// issue selection
// one grant per unit class, registered issue ports
//------------------------------

module rs_issue_select #(
	parameter int rs_size = 12
) (
	input  logic                                          clock,
	input  logic                                          rst_n,
	input  logic                                          flush,
	input  logic                                          ld_ready,
	input  logic                                          st_ready,
	input  logic [rs_size-1:0]                            entry_busy,
	input  rs_pkg::fu_kind_t [rs_size-1:0]                entry_fu,
	input  logic [rs_size-1:0][rs_pkg::op_w-1:0]          entry_op,
	input  logic [rs_size-1:0][rs_pkg::tag_w-1:0]         entry_dest,
	input  logic [rs_size-1:0][rs_pkg::tag_w-1:0]         entry_src1,
	input  logic [rs_size-1:0]                            entry_src1_ready,
	input  logic [rs_size-1:0][rs_pkg::tag_w-1:0]         entry_src2,
	input  logic [rs_size-1:0]                            entry_src2_ready,
	output logic [rs_size-1:0]                            issue_grant,
	output logic [rs_pkg::num_fu-1:0]                     issue_valid,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::op_w-1:0]   issue_op,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_dest,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_src1,
	output logic [rs_pkg::num_fu-1:0][rs_pkg::tag_w-1:0]  issue_src2
);

	import rs_pkg::*;

	logic [num_fu-1:0]                class_ok;
	logic [num_fu-1:0]                class_any;
	logic [num_fu-1:0][rs_size-1:0]   class_req;
	logic [num_fu-1:0][rs_size-1:0]   class_grant;
	// granted entry fields per class
	logic [num_fu-1:0][op_w-1:0]      sel_op;
	logic [num_fu-1:0][tag_w-1:0]     sel_dest;
	logic [num_fu-1:0][tag_w-1:0]     sel_src1;
	logic [num_fu-1:0][tag_w-1:0]     sel_src2;

	// memory classes wait for queue space
	always_comb begin
		class_ok = '1;
		class_ok[fu_ld] = ld_ready;
		class_ok[fu_st] = st_ready;
	end

	// ready = busy, both operands, class matches, unit can accept
	always_comb begin
		for (int k = 0; k < num_fu; k++) begin
			for (int i = 0; i < rs_size; i++) begin
				class_req[k][i] = entry_busy[i] & entry_src1_ready[i] & entry_src2_ready[i]
					& class_ok[k] & (entry_fu[i] == fu_kind_t'(k));
			end
		end
	end

	// one picker per class, flush holds back every grant
	for (genvar k = 0; k < num_fu; k++) begin : g_class
		rs_priority_pick #(
			.pick_width (rs_size)
		) class_pick_inst (
			.enable      (~flush),
			.request     (class_req[k]),
			.grant       (class_grant[k]),
			.any_request (class_any[k])
		);
	end

	// release mask and field mux, grants are one-hot per class
	always_comb begin
		issue_grant = '0;
		sel_op   = '0;
		sel_dest = '0;
		sel_src1 = '0;
		sel_src2 = '0;
		for (int k = 0; k < num_fu; k++) begin
			issue_grant = issue_grant | class_grant[k];
			for (int i = 0; i < rs_size; i++) begin
				if (class_grant[k][i]) begin
					sel_op[k]   = entry_op[i];
					sel_dest[k] = entry_dest[i];
					sel_src1[k] = entry_src1[i];
					sel_src2[k] = entry_src2[i];
				end
			end
		end
	end

	//------------------------------
	// issue registers
	//------------------------------

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			issue_valid <= '0;
		end else begin
			issue_valid <= class_any;
		end
	end

	// fields only move when the class issues
	always_ff @(posedge clock) begin
		for (int k = 0; k < num_fu; k++) begin
			if (|class_grant[k]) begin
				issue_op[k]   <= sel_op[k];
				issue_dest[k] <= sel_dest[k];
				issue_src1[k] <= sel_src1[k];
				issue_src2[k] <= sel_src2[k];
			end
		end
	end

	// an entry belongs to a single class, so classes never share a grant
	grant_disjoint: assert property (@(posedge clock) disable iff (!rst_n)
		$countones(class_grant) == $countones(issue_grant))
	else $error("rs_issue_select: entry granted to two classes");

endmodule

// ==== src/rs_entry_table.sv ====
//------------------------------
// reservation station entry table
// dispatch write, wakeup, issue release, flush, full flag
//------------------------------

module rs_entry_table #(
	parameter int rs_size = 12
) (
	input  logic                                  clock,
	input  logic                                  rst_n,
	input  logic                                  flush,
	input  logic                                  cdb_valid,
	input  logic [rs_pkg::tag_w-1:0]              cdb_tag,
	input  logic                                  dispatch_valid,
	input  rs_pkg::fu_kind_t                      dispatch_fu,
	input  logic [rs_pkg::op_w-1:0]               dispatch_op,
	input  logic [rs_pkg::tag_w-1:0]              dispatch_dest,
	input  logic [rs_pkg::tag_w-1:0]              dispatch_src1,
	input  logic                                  dispatch_src1_ready,
	input  logic [rs_pkg::tag_w-1:0]              dispatch_src2,
	input  logic                                  dispatch_src2_ready,
	input  logic [rs_size-1:0]                    src1_hit,
	input  logic [rs_size-1:0]                    src2_hit,
	input  logic [rs_size-1:0]                    issue_grant,
	output logic                                  rs_full,
	output logic [rs_size-1:0]                    entry_busy,
	output rs_pkg::fu_kind_t [rs_size-1:0]        entry_fu,
	output logic [rs_size-1:0][rs_pkg::op_w-1:0]  entry_op,
	output logic [rs_size-1:0][rs_pkg::tag_w-1:0] entry_dest,
	output logic [rs_size-1:0][rs_pkg::tag_w-1:0] entry_src1,
	output logic [rs_size-1:0]                    entry_src1_ready,
	output logic [rs_size-1:0][rs_pkg::tag_w-1:0] entry_src2,
	output logic [rs_size-1:0]                    entry_src2_ready
);

	import rs_pkg::*;

	// control state
	logic [rs_size-1:0]              busy_q;
	logic                            full_q;
	// payload, meaningful only while busy
	fu_kind_t [rs_size-1:0]          fu_q;
	logic [rs_size-1:0][op_w-1:0]    op_q;
	logic [rs_size-1:0][tag_w-1:0]   dest_q;
	logic [rs_size-1:0][tag_w-1:0]   src1_q;
	logic [rs_size-1:0][tag_w-1:0]   src2_q;
	logic [rs_size-1:0]              src1_rdy_q;
	logic [rs_size-1:0]              src2_rdy_q;

	logic [rs_size-1:0] alloc_grant;
	logic [rs_size-1:0] busy_d;
	logic               src1_bypass;
	logic               src2_bypass;

	//------------------------------
	// free slot choice
	//------------------------------

	// highest free index, only when the dispatch is taken
	rs_priority_pick #(
		.pick_width (rs_size)
	) free_pick_inst (
		.enable      (dispatch_valid & ~full_q),
		.request     (~busy_q),
		.grant       (alloc_grant),
		.any_request ()
	);

	// source produced on the bus this very cycle
	assign src1_bypass = cdb_valid & (dispatch_src1 == cdb_tag);
	assign src2_bypass = cdb_valid & (dispatch_src2 == cdb_tag);

	// freed slots are not reused until the next cycle
	assign busy_d = (busy_q & ~issue_grant) | alloc_grant;

	//------------------------------
	// state update
	//------------------------------

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			busy_q <= '0;
			full_q <= 1'b0;
		end else begin
			busy_q <= busy_d;
			full_q <= &busy_d;
		end
	end

	// new entry written, otherwise wakeups accumulate
	always_ff @(posedge clock) begin
		for (int i = 0; i < rs_size; i++) begin
			if (alloc_grant[i]) begin
				fu_q[i]       <= dispatch_fu;
				op_q[i]       <= dispatch_op;
				dest_q[i]     <= dispatch_dest;
				src1_q[i]     <= dispatch_src1;
				src2_q[i]     <= dispatch_src2;
				src1_rdy_q[i] <= dispatch_src1_ready | src1_bypass;
				src2_rdy_q[i] <= dispatch_src2_ready | src2_bypass;
			end else begin
				src1_rdy_q[i] <= entry_src1_ready[i];
				src2_rdy_q[i] <= entry_src2_ready[i];
			end
		end
	end

	//------------------------------
	// flat view out
	//------------------------------

	assign rs_full    = full_q;
	assign entry_busy = busy_q;
	assign entry_fu   = fu_q;
	assign entry_op   = op_q;
	assign entry_dest = dest_q;
	assign entry_src1 = src1_q;
	assign entry_src2 = src2_q;
	// this cycle's broadcast already counts
	assign entry_src1_ready = src1_rdy_q | src1_hit;
	assign entry_src2_ready = src2_rdy_q | src2_hit;

	// issue may only release entries that hold an instruction
	grant_busy: assert property (@(posedge clock) disable iff (!rst_n)
		(issue_grant & ~busy_q) == '0)
	else $error("rs_entry_table: grant to an idle entry");

endmodule

// ==== src/rs_tag_cam.sv ====
//------------------------------
// result bus tag match
// compares the broadcast tag against both sources of every entry
//------------------------------

module rs_tag_cam #(
	parameter int rs_size = 12
) (
	input  logic                                    cdb_valid,
	input  logic [rs_pkg::tag_w-1:0]                cdb_tag,
	input  logic [rs_size-1:0]                      entry_busy,
	input  logic [rs_size-1:0][rs_pkg::tag_w-1:0]   entry_src1,
	input  logic [rs_size-1:0][rs_pkg::tag_w-1:0]   entry_src2,
	output logic [rs_size-1:0]                      src1_hit,
	output logic [rs_size-1:0]                      src2_hit
);

	// all entries compared in parallel
	for (genvar i = 0; i < rs_size; i++) begin : g_match
		// idle entries hold stale tags, never let them match
		assign src1_hit[i] = cdb_valid & entry_busy[i] & (entry_src1[i] == cdb_tag);
		assign src2_hit[i] = cdb_valid & entry_busy[i] & (entry_src2[i] == cdb_tag);
	end

endmodule

// ==== src/rs_priority_pick.sv ====
//------------------------------
// fixed priority picker
// two level tree of four wide groups, highest index wins
//------------------------------

module rs_priority_pick #(
	parameter int pick_width = 12
) (
	input  logic                  enable,
	input  logic [pick_width-1:0] request,
	output logic [pick_width-1:0] grant,
	output logic                  any_request
);

	// requests padded up to whole groups of four
	localparam int n_grp = (pick_width + 3) / 4;
	localparam int pad_w = n_grp * 4;

	logic [pad_w-1:0] req_pad;
	logic [pad_w-1:0] grant_pad;
	// group level request and enable, top picker is four wide too
	logic [3:0]       grp_req;
	logic [3:0]       grp_en;

	// one four wide node, bit 3 first
	function automatic logic [3:0] pick4(input logic en, input logic [3:0] req);
		logic [3:0] g;
		g[3] = en & req[3];
		g[2] = en & req[2] & ~req[3];
		g[1] = en & req[1] & ~req[2] & ~req[3];
		g[0] = en & req[0] & ~req[1] & ~req[2] & ~req[3];
		return g;
	endfunction

	always_comb begin
		req_pad = '0;
		req_pad[pick_width-1:0] = request;
	end

	if (n_grp > 4) begin : g_size_check
		$error("rs_priority_pick handles at most 16 requests");
	end

	// bottom level, unused groups never request
	for (genvar g = 0; g < 4; g++) begin : g_group
		if (g < n_grp) begin : g_used
			assign grp_req[g] = |req_pad[4*g +: 4];
			assign grant_pad[4*g +: 4] = pick4(grp_en[g], req_pad[4*g +: 4]);
		end else begin : g_unused
			assign grp_req[g] = 1'b0;
		end
	end

	// top level picks the highest requesting group
	assign grp_en = pick4(enable, grp_req);

	assign grant = grant_pad[pick_width-1:0];
	assign any_request = |grp_req;

	always_comb begin
		assert #0 ($onehot0(grant))
		else $error("rs_priority_pick: more than one grant");
	end

endmodule

// ==== src/rs_pkg.sv ====
//------------------------------
// rs package
// shared widths and unit class encoding for the
// reservation station
//------------------------------

package rs_pkg;

	//------------------------------
	// widths
	//------------------------------

	// physical register tag
	localparam int tag_w = 6;

	// operation code carried to the unit
	localparam int op_w = 4;

	// number of functional unit classes, one issue slice each
	localparam int num_fu = 5;

	//------------------------------
	// unit classes
	//------------------------------

	// value doubles as the issue port slice index
	typedef enum logic [2:0] {
		// integer alu
		fu_alu  = 3'd0,
		// load, gated by ld_ready
		fu_ld   = 3'd1,
		// store, gated by st_ready
		fu_st   = 3'd2,
		// multiplier
		fu_mult = 3'd3,
		// branch unit
		fu_br   = 3'd4
	} fu_kind_t;

endpackage
